// File: verilog/nn_pkg.sv
// shared widths, counts and bus structs for the hidden layer
// imported by the RTL and the testbench
`default_nettype none

package nn_pkg;

	localparam int DATA_W   = 16; // pixel and weight width
	localparam int ACC_W    = 32; // product and running sum
	localparam int N_LANES  = 4;  // multipliers, weights per step
	localparam int NEURON_W = 6;  // 64 hidden neurons
	localparam int GROUP_W  = NEURON_W - $clog2(N_LANES); // group address bits

	typedef logic signed [DATA_W-1:0] pixel_t;
	typedef logic signed [DATA_W-1:0] weight_t;

	// one weight per lane, lane 0 sits in the low bits
	typedef struct packed {
		weight_t [N_LANES-1:0] w;
	} weight_word_t;

	// accumulate request from a lane, also reused for readout
	typedef struct packed {
		logic [NEURON_W-1:0] neuron; // target hidden neuron
		logic [ACC_W-1:0]    value;  // product to add
		logic                replace; // first pixel, overwrite the sum
	} acc_req_t;

	// readout strobe from outside
	typedef struct packed {
		logic                rd;
		logic [NEURON_W-1:0] neuron;
	} rd_req_t;

endpackage

`default_nettype wire

// File: verilog/layer_sequencer.sv
// layer control: accepts one pixel per group, starts the lanes,
// waits on all lane dones and walks the group address
`timescale 1ns/1ns
`default_nettype none

module layer_sequencer #(
	parameter int N_GROUPS = 16
) (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       i_start,
	input  wire logic                       i_empty,
	input  wire logic                       i_read_done,
	input  wire nn_pkg::pixel_t             i_din,
	input  wire logic                       i_first,
	input  wire logic [nn_pkg::N_LANES-1:0] i_lane_done,
	output      logic                       o_ready,
	output      logic                       o_start_mul,
	output      nn_pkg::pixel_t             o_pixel,
	output      logic [nn_pkg::GROUP_W-1:0] o_group,
	output      logic                       o_first,
	output      logic                       o_next_in,
	output      logic                       o_all_done
);
	import nn_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		OP_START, // waiting for a pixel
		OP,       // lanes busy
		OP_DONE,  // one cycle, step the group
		ALL_DONE
	} state_t;

	localparam logic [GROUP_W-1:0] LAST_GROUP = GROUP_W'(N_GROUPS - 1);

	state_t             cs, ns;
	logic [N_LANES-1:0] done_flags; // one per lane
	logic               accept;

	assign accept = (cs == OP_START) && !i_empty; // pixel taken this edge

	always_comb begin
		ns = cs;
		case (cs)
			IDLE:     if (i_start) ns = OP_START;
			OP_START: if (!i_empty) ns = OP;
			OP:       if (&done_flags) ns = OP_DONE; // every lane written back
			OP_DONE: begin
				if (i_read_done && i_empty) ns = ALL_DONE; // source drained
				else ns = OP_START;
			end
			ALL_DONE: ns = ALL_DONE; // park, readout only
			default:  ns = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) cs <= IDLE;
		else cs <= ns;
	end

	// lanes start the cycle after the accept
	always_ff @(posedge clk) begin
		if (reset) o_start_mul <= 1'b0;
		else o_start_mul <= accept;
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			o_pixel <= i_din;
			o_first <= i_first; // replace instead of add
		end
	end

	always_ff @(posedge clk) begin
		if (reset) done_flags <= '0;
		else if (cs == OP_DONE) done_flags <= '0;
		else done_flags <= done_flags | i_lane_done; // sticky until group end
	end

	// group address
	always_ff @(posedge clk) begin
		if (reset) o_group <= '0;
		else if (cs == IDLE) o_group <= '0;
		else if (cs == OP_DONE) begin
			if (o_group == LAST_GROUP) o_group <= '0; // wrap, next pixel
			else o_group <= o_group + 1'b1;
		end
	end

	assign o_ready    = (cs == OP_START);
	assign o_next_in  = (cs == OP_DONE) && (o_group == LAST_GROUP);
	assign o_all_done = (cs == ALL_DONE);

endmodule

`default_nettype wire

// File: verilog/mac_lane.sv
// one multiplier lane: signed shift-add over DATA_W cycles, then holds an
// accumulate request for its neuron until the arbiter grants it
`timescale 1ns/1ns
`default_nettype none

module mac_lane #(
	parameter int LANE = 0 // lane index inside the group
) (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       i_start,
	input  wire nn_pkg::pixel_t             i_pixel,
	input  wire nn_pkg::weight_t            i_weight,
	input  wire logic [nn_pkg::GROUP_W-1:0] i_group,
	input  wire logic                       i_first,
	input  wire logic                       i_grant,
	output      nn_pkg::acc_req_t           o_req,
	output      logic                       o_req_valid
);
	import nn_pkg::*;

	localparam int CNT_W = $clog2(DATA_W);

	logic              busy;
	logic [CNT_W-1:0]  cnt;    // bit being processed
	logic [ACC_W-1:0]  mcand;  // pixel, shifted left each step
	logic [DATA_W-1:0] mplier; // weight, shifted right each step
	logic [ACC_W-1:0]  prod;

	// control
	always_ff @(posedge clk) begin
		if (reset) begin
			busy        <= 1'b0;
			cnt         <= '0;
			o_req_valid <= 1'b0;
		end else if (i_start) begin
			busy <= 1'b1;
			cnt  <= '0;
		end else if (busy) begin
			cnt <= cnt + 1'b1;
			if (cnt == CNT_W'(DATA_W - 1)) begin
				busy        <= 1'b0;
				o_req_valid <= 1'b1; // product ready
			end
		end else if (o_req_valid && i_grant) begin
			o_req_valid <= 1'b0;
		end
	end

	// datapath
	always_ff @(posedge clk) begin
		if (i_start) begin
			mcand <= {{(ACC_W - DATA_W){i_pixel[DATA_W-1]}}, i_pixel}; // sign extend
			prod  <= '0;
		end else if (busy) begin
			// weight msb carries negative weight in two's complement
			if (mplier[0]) begin
				if (cnt == CNT_W'(DATA_W - 1)) prod <= prod - mcand;
				else prod <= prod + mcand;
			end
			mcand  <= mcand << 1;
			mplier <= mplier >> 1;
		end else begin
			mplier <= i_weight; // follows the bus, frozen by start
		end
	end

	always_comb begin
		o_req.neuron  = NEURON_W'(int'(i_group) * N_LANES + LANE);
		o_req.value   = prod;
		o_req.replace = i_first;
	end

endmodule

`default_nettype wire

// File: verilog/hidden_arbiter.sv
// fixed priority access to the sum memory, lane 0 first, readout last
// routes each memory done back to whoever owned the request
`timescale 1ns/1ns
`default_nettype none

module hidden_arbiter (
	input  wire logic                                 clk,
	input  wire logic                                 reset,
	input  wire nn_pkg::acc_req_t [nn_pkg::N_LANES-1:0] i_lane_req,
	input  wire logic [nn_pkg::N_LANES-1:0]           i_lane_valid,
	input  wire nn_pkg::rd_req_t                      i_rd,
	output      logic [nn_pkg::N_LANES-1:0]           o_lane_grant,
	output      nn_pkg::acc_req_t                     o_mem_req,
	output      logic                                 o_mem_write,
	output      logic                                 o_mem_valid,
	input  wire logic                                 i_mem_done,
	output      logic [nn_pkg::N_LANES-1:0]           o_lane_done,
	output      logic                                 o_rd_valid
);
	import nn_pkg::*;

	logic             rd_grant;
	logic [N_LANES:0] own_q1, own_q2; // top bit marks readout

	always_comb begin
		o_lane_grant = '0;
		rd_grant     = 1'b0;
		o_mem_req    = '0;
		o_mem_write  = 1'b0;
		o_mem_valid  = 1'b0;
		if (i_rd.rd) begin // lowest priority, dropped if it loses
			rd_grant    = 1'b1;
			o_mem_req   = '{neuron: i_rd.neuron, value: '0, replace: 1'b0};
			o_mem_valid = 1'b1;
		end
		// walk down so the lowest index wins
		for (int i = N_LANES - 1; i >= 0; i--) begin
			if (i_lane_valid[i]) begin
				o_lane_grant    = '0;
				o_lane_grant[i] = 1'b1;
				rd_grant        = 1'b0;
				o_mem_req       = i_lane_req[i];
				o_mem_write     = 1'b1;
				o_mem_valid     = 1'b1;
			end
		end
	end

	// owner record, two deep to match memory latency
	always_ff @(posedge clk) begin
		if (reset) begin
			own_q1 <= '0;
			own_q2 <= '0;
		end else begin
			own_q1 <= {rd_grant, o_lane_grant};
			own_q2 <= own_q1;
		end
	end

	assign o_lane_done = i_mem_done ? own_q2[N_LANES-1:0] : '0;
	assign o_rd_valid  = i_mem_done & own_q2[N_LANES]; // readout data valid now

endmodule

`default_nettype wire

// File: verilog/hidden_acc_ram.sv
// hidden neuron sums, read on the grant cycle, add and write one cycle later
// done pulses the cycle after the write, read data valid with it
`timescale 1ns/1ns
`default_nettype none

module hidden_acc_ram #(
	parameter int N_GROUPS = 16
) (
	input  wire logic                     clk,
	input  wire logic                     reset,
	input  wire nn_pkg::acc_req_t         i_req,
	input  wire logic                     i_write, // lane write-back, else readout
	input  wire logic                     i_valid,
	output      logic                     o_done,
	output      logic [nn_pkg::ACC_W-1:0] o_rd_data
);
	import nn_pkg::*;

	localparam int DEPTH  = N_GROUPS * N_LANES;
	localparam int ADDR_W = $clog2(DEPTH);

	logic [ACC_W-1:0] mem [DEPTH];

	logic             s1_valid;
	logic             s1_write;
	acc_req_t         s1_req;
	logic [ACC_W-1:0] s1_old; // stored sum for the s1 neuron

	always_ff @(posedge clk) begin
		if (reset) s1_valid <= 1'b0;
		else s1_valid <= i_valid;
	end

	// stage one: read
	always_ff @(posedge clk) begin
		s1_write <= i_write;
		s1_req   <= i_req;
		if (i_valid) s1_old <= mem[i_req.neuron[ADDR_W-1:0]];
	end

	// stage two: add and write back, wraps at 32 bits
	always_ff @(posedge clk) begin
		if (s1_valid && s1_write) begin
			if (s1_req.replace) mem[s1_req.neuron[ADDR_W-1:0]] <= s1_req.value;
			else mem[s1_req.neuron[ADDR_W-1:0]] <= s1_old + s1_req.value;
		end
	end

	always_ff @(posedge clk) begin
		if (s1_valid && !s1_write) o_rd_data <= s1_old; // readout only
	end

	always_ff @(posedge clk) begin
		if (reset) o_done <= 1'b0;
		else o_done <= s1_valid;
	end

endmodule

`default_nettype wire

// File: verilog/hidden_layer_top.sv
// first layer of the accelerator, four mac lanes sharing one sum memory
// readout allowed once o_all_done is up
`timescale 1ns/1ns
`default_nettype none

module hidden_layer_top #(
	parameter int N_GROUPS = 16 // groups of four neurons
) (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic                    i_start,
	input  wire nn_pkg::pixel_t          i_din,
	input  wire nn_pkg::weight_word_t    i_weights,
	input  wire logic                    i_first,
	input  wire logic                    i_empty,
	input  wire logic                    i_read_done,
	input  wire nn_pkg::rd_req_t         i_rd,
	output      logic                    o_ready,
	output      logic                    o_next_in,
	output      logic                    o_all_done,
	output      logic [nn_pkg::ACC_W-1:0] o_rd_data,
	output      logic                    o_rd_valid
);
	import nn_pkg::*;

	logic               start_mul; // one pulse, all lanes
	pixel_t             pixel;
	logic [GROUP_W-1:0] group;
	logic               first;

	acc_req_t [N_LANES-1:0] lane_req;
	logic [N_LANES-1:0]     lane_valid;
	logic [N_LANES-1:0]     lane_grant;
	logic [N_LANES-1:0]     lane_done;

	// shared memory bus
	acc_req_t mem_req;
	logic     mem_write;
	logic     mem_valid;
	logic     mem_done;

	layer_sequencer #(.N_GROUPS(N_GROUPS)) u_seq (
		.clk         (clk),
		.reset       (reset),
		.i_start     (i_start),
		.i_empty     (i_empty),
		.i_read_done (i_read_done),
		.i_din       (i_din),
		.i_first     (i_first),
		.i_lane_done (lane_done),
		.o_ready     (o_ready),
		.o_start_mul (start_mul),
		.o_pixel     (pixel),
		.o_group     (group),
		.o_first     (first),
		.o_next_in   (o_next_in),
		.o_all_done  (o_all_done)
	);

	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		mac_lane #(.LANE(g)) u_lane (
			.clk         (clk),
			.reset       (reset),
			.i_start     (start_mul),
			.i_pixel     (pixel),
			.i_weight    (i_weights.w[g]),
			.i_group     (group),
			.i_first     (first),
			.i_grant     (lane_grant[g]),
			.o_req       (lane_req[g]),
			.o_req_valid (lane_valid[g])
		);
	end

	hidden_arbiter u_arb (
		.clk          (clk),
		.reset        (reset),
		.i_lane_req   (lane_req),
		.i_lane_valid (lane_valid),
		.i_rd         (i_rd),
		.o_lane_grant (lane_grant),
		.o_mem_req    (mem_req),
		.o_mem_write  (mem_write),
		.o_mem_valid  (mem_valid),
		.i_mem_done   (mem_done),
		.o_lane_done  (lane_done),
		.o_rd_valid   (o_rd_valid)
	);

	hidden_acc_ram #(.N_GROUPS(N_GROUPS)) u_ram (
		.clk       (clk),
		.reset     (reset),
		.i_req     (mem_req),
		.i_write   (mem_write),
		.i_valid   (mem_valid),
		.o_done    (mem_done),
		.o_rd_data (o_rd_data)
	);

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
// testbench clock, 4 ns period, with a power-on reset held for 10 cycles
// reset released on a falling edge
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
	parameter int PERIOD       = 4,
	parameter int RESET_CYCLES = 10
) (
	output logic o_clk,
	output logic o_reset
);

	initial o_clk = 1'b0;
	always #(PERIOD / 2) o_clk = ~o_clk;

	initial begin
		o_reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clk);
		@(negedge o_clk) o_reset = 1'b0; // released away from the active edge
	end

endmodule

`default_nettype wire

// File: dv/hidden_layer_asserts.sv
// protocol checks bound into hidden_layer_top
// failures counted in fail_count for the testbench summary
`timescale 1ns/1ns
`default_nettype none

module hidden_layer_asserts (
	input wire logic            clk,
	input wire logic            reset,
	input wire logic            o_ready,
	input wire logic            o_all_done,
	input wire logic            o_next_in,
	input wire logic            o_rd_valid,
	input wire nn_pkg::rd_req_t i_rd
);

	int fail_count = 0;

	// waiting state and done state never overlap
	a_ready_vs_done: assert property (@(posedge clk) disable iff (reset)
		!(o_ready && o_all_done))
		else begin
			$error("o_ready high together with o_all_done");
			fail_count++;
		end

	a_rd_latency: assert property (@(posedge clk) disable iff (reset)
		i_rd.rd |-> ##2 o_rd_valid)
		else begin
			$error("o_rd_valid missing 2 cycles after read strobe");
			fail_count++;
		end

	a_rd_no_stray: assert property (@(posedge clk) disable iff (reset)
		o_rd_valid |-> $past(i_rd.rd, 2))
		else begin
			$error("o_rd_valid without a read strobe 2 cycles before");
			fail_count++;
		end

	a_next_pulse: assert property (@(posedge clk) disable iff (reset)
		o_next_in |=> !o_next_in) // one cycle only
		else begin
			$error("o_next_in held longer than one cycle");
			fail_count++;
		end

endmodule

`default_nettype wire

// File: dv/tb_hidden_layer.sv
// testbench for hidden_layer_top: feeds pixel passes, models the sums,
// reads all neurons back and compares against the model
`timescale 1ns/1ns
`default_nettype none

module tb_hidden_layer;
	import nn_pkg::*;

	localparam int N_GROUPS = 16;
	localparam int N_NEURON = N_GROUPS * N_LANES;
	localparam int N_PASSES = 8; // pixel passes over the whole run
	localparam int WATCHDOG_CYCLES = N_PASSES * N_GROUPS * 40 + 4000;

	logic         clk, por_reset, run_reset, dut_reset;
	logic         i_start, i_first, i_empty, i_read_done;
	pixel_t       i_din;
	weight_word_t i_weights;
	rd_req_t      i_rd;
	logic         o_ready, o_next_in, o_all_done, o_rd_valid;
	logic [ACC_W-1:0] o_rd_data;

	integer      seed = 32'hfc2e;
	int          errors = 0;
	int          tests_failed = 0;
	int          tests_run = 0;
	int          next_count = 0; // o_next_in pulses this run
	int          grp = 0;        // group the next accept lands in
	logic [ACC_W-1:0] model_sum [N_NEURON];
	int          exp_q [$];      // neurons with a read outstanding

	assign dut_reset = por_reset | run_reset;

	clk_gen #(.PERIOD(4), .RESET_CYCLES(10)) u_clk (.o_clk(clk), .o_reset(por_reset));

	hidden_layer_top #(.N_GROUPS(N_GROUPS)) u_dut (
		.clk(clk), .reset(dut_reset), .i_start(i_start), .i_din(i_din),
		.i_weights(i_weights), .i_first(i_first), .i_empty(i_empty),
		.i_read_done(i_read_done), .i_rd(i_rd), .o_ready(o_ready),
		.o_next_in(o_next_in), .o_all_done(o_all_done), .o_rd_data(o_rd_data),
		.o_rd_valid(o_rd_valid)
	);

	bind hidden_layer_top hidden_layer_asserts u_asserts (.*);

	// expected sum after one product, 32-bit wrap
	function automatic logic [ACC_W-1:0] ref_sum(input logic [ACC_W-1:0] old,
		input pixel_t px, input weight_t w, input logic first);
		logic signed [ACC_W-1:0] p;
		logic signed [ACC_W-1:0] q;
		p = ACC_W'(px);
		q = ACC_W'(w);
		if (first) return p * q;
		return old + p * q;
	endfunction

	// readout comparison
	always @(negedge clk) begin
		int n;
		if (o_rd_valid) begin
			if (exp_q.size() == 0) begin
				$display("o_rd_valid came with no read outstanding");
				errors++;
			end else begin
				n = exp_q.pop_front();
				if (o_rd_data !== model_sum[n]) begin
					$display("error: o_rd_data neuron %0d got %h expected %h",
						n, o_rd_data, model_sum[n]);
					errors++;
				end
			end
		end
		if (o_next_in) next_count++;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles, DUT stopped responding", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	task automatic restart_dut();
		@(negedge clk) run_reset = 1'b1;
		i_read_done = 1'b0; // source refilled for the next run
		repeat (10) @(negedge clk);
		run_reset = 1'b0;
	endtask

	task automatic start_run();
		@(negedge clk) i_start = 1'b1;
		@(negedge clk) i_start = 1'b0;
		if (o_ready !== 1'b1) begin
			$display("error: o_ready got %h expected 1", o_ready);
			errors++;
		end
		grp = 0;
		next_count = 0;
	endtask

	// one pixel; waits for o_ready, optional stall with i_empty high
	task automatic feed_pixel(input pixel_t px, input weight_word_t ww,
		input logic first, input int stall);
		int n;
		while (!o_ready) @(negedge clk);
		for (int s = 0; s < stall; s++) begin
			@(negedge clk);
			if (o_ready !== 1'b1) begin
				$display("error: o_ready got %h expected 1 during stall", o_ready);
				errors++;
			end
		end
		i_din     = px;
		i_weights = ww;
		i_first   = first;
		i_empty   = 1'b0; // accepted on the next rising edge
		for (int l = 0; l < N_LANES; l++) begin
			n = grp * N_LANES + l;
			model_sum[n] = ref_sum(model_sum[n], px, ww.w[l], first);
		end
		grp = (grp + 1) % N_GROUPS;
		@(negedge clk) i_empty = 1'b1;
	endtask

	// kind 1 forces extreme values into group 0 to wrap the sums
	task automatic feed_pass(input logic first, input int kind, input int max_stall);
		pixel_t       px;
		weight_word_t ww;
		int           stall;
		for (int g = 0; g < N_GROUPS; g++) begin
			px = pixel_t'($random(seed));
			for (int l = 0; l < N_LANES; l++) ww.w[l] = weight_t'($random(seed));
			if (kind == 1 && g == 0) begin
				px = 16'sh8000;
				for (int l = 0; l < N_LANES; l++) ww.w[l] = 16'sh8000;
			end
			stall = (max_stall > 0) ? ({$random(seed)} % (max_stall + 1)) : 0;
			feed_pixel(px, ww, first, stall);
		end
	endtask

	// raise read done and check the done state holds
	task automatic finish_run(input int hold);
		@(negedge clk) i_read_done = 1'b1;
		while (!o_all_done) @(negedge clk);
		for (int c = 0; c < hold; c++) begin
			@(negedge clk);
			if (o_all_done !== 1'b1) begin
				$display("error: o_all_done got %h expected 1", o_all_done);
				errors++;
			end
			if (o_ready !== 1'b0) begin
				$display("error: o_ready got %h expected 0", o_ready);
				errors++;
			end
		end
	endtask

	task automatic read_all(input logic reverse);
		for (int k = 0; k < N_NEURON; k++) begin
			@(negedge clk);
			i_rd.rd     = 1'b1;
			i_rd.neuron = NEURON_W'(reverse ? N_NEURON - 1 - k : k);
			exp_q.push_back(reverse ? N_NEURON - 1 - k : k);
		end
		@(negedge clk) i_rd = '0;
		while (exp_q.size() != 0) @(negedge clk);
	endtask

	task automatic check_next_count(input int expected);
		if (next_count != expected) begin
			$display("error: o_next_in count got %h expected %h", next_count, expected);
			errors++;
		end
	endtask

	task automatic report_test(input int num, input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("test %0d %s: passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s: failed with %0d errors", num, name, errors - err_before);
		end
	endtask

	initial begin
		int e0;
		int assert_fails;
		run_reset   = 1'b0;
		i_start     = 1'b0;
		i_first     = 1'b0;
		i_empty     = 1'b1;
		i_read_done = 1'b0;
		i_din       = '0;
		i_weights   = '0;
		i_rd        = '0;
		for (int n = 0; n < N_NEURON; n++) model_sum[n] = '0;

		@(negedge clk);
		while (por_reset) @(negedge clk);

		e0 = errors; // reset state, outputs quiet until start
		repeat (5) begin
			@(negedge clk);
			if ({o_ready, o_next_in, o_all_done, o_rd_valid} !== 4'b0) begin
				$display("error: outputs {ready,next,done,rd_valid} got %h expected 0",
					{o_ready, o_next_in, o_all_done, o_rd_valid});
				errors++;
			end
		end
		report_test(1, "reset state", e0);

		e0 = errors;
		start_run();
		feed_pass(1'b1, 0, 0);
		finish_run(4);
		check_next_count(1);
		read_all(1'b0);
		report_test(2, "single first pass", e0);

		e0 = errors;
		restart_dut();
		start_run();
		feed_pass(1'b1, 1, 0);
		repeat (3) feed_pass(1'b0, 1, 0);
		finish_run(4);
		check_next_count(4);
		read_all(1'b0);
		report_test(3, "accumulate with wrap", e0);

		e0 = errors;
		restart_dut();
		start_run();
		feed_pass(1'b1, 0, 12);
		feed_pass(1'b0, 0, 12);
		finish_run(4);
		read_all(1'b0);
		report_test(4, "empty stall", e0);

		e0 = errors;
		restart_dut();
		start_run();
		feed_pass(1'b1, 0, 0);
		finish_run(20);
		report_test(5, "all done holds", e0);

		e0 = errors;
		read_all(1'b1); // reverse order, one strobe per cycle
		report_test(6, "back to back readout", e0);

		assert_fails = u_dut.u_asserts.fail_count;
		$display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, errors, assert_fails);
		if (errors == 0 && tests_failed == 0 && assert_fails == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/nn_pkg.sv
verilog/layer_sequencer.sv
verilog/mac_lane.sv
verilog/hidden_arbiter.sv
verilog/hidden_acc_ram.sv
verilog/hidden_layer_top.sv
dv/clk_gen.sv
dv/hidden_layer_asserts.sv
dv/tb_hidden_layer.sv

// File: Makefile
# Verilator build for the hidden layer testbench

TOP := tb_hidden_layer
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
